// ==== rv32_int_pipe.f ====
source/rv_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/alu.sv
source/rv32_int_pipe.sv
bench/rv32_int_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: rv32_int_pipe

sources:
  - source/rv_pkg.sv
  - source/instr_decoder.sv
  - source/reg_file.sv
  - source/operand_forward.sv
  - source/alu.sv
  - source/rv32_int_pipe.sv
  - target: test
    files:
      - bench/rv32_int_pipe_tb.sv

// ==== bench/rv32_int_pipe_tb.sv ====
// Testbench for the integer pipeline with reference model, retire checks and timeout
module rv32_int_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]     tag;      // Edge that captured the issue
        logic [2:0]      test_id;
        logic            writes;
        rv_pkg::retire_t exp;
    } expect_t;

    localparam int SEED_SLOTS  = 62;
    localparam int R_SLOTS     = 80;
    localparam int I_SLOTS     = 70;
    localparam int CHAIN_SLOTS = 60;
    localparam int X0_SLOTS    = 16;
    localparam int MIX_SLOTS   = 600 * 3; // Up to two idles per issue
    localparam int CYCLE_LIMIT = 8 + SEED_SLOTS + R_SLOTS + I_SLOTS + CHAIN_SLOTS
                                 + X0_SLOTS + MIX_SLOTS + 6 + 2 + 20;

    logic            clk = 1'b0;
    logic            rst;
    logic            issue;
    rv_pkg::instr_t  instr;
    rv_pkg::retire_t retire;
    rv_pkg::word_t   model_regs [rv_pkg::REG_COUNT];
    expect_t         expected_q [$];
    int              edge_count = 0;
    int              errors = 0;

    rv32_int_pipe DUT (.clk(clk), .rst(rst), .issue(issue), .instr(instr), .retire(retire));

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    return "seed";
            3'd1:    return "r_type";
            3'd2:    return "i_type";
            3'd3:    return "chain";
            3'd4:    return "x0_unsupported";
            default: return "random_mix";
        endcase
    endfunction

    function automatic rv_pkg::instr_t enc_r(input logic alt, input rv_pkg::reg_addr_t rs2,
            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm,
            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
        return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::instr_t enc_unsupported();
        rv_pkg::instr_t r;
        logic [6:0]     opc;
        r = $urandom;
        case ($urandom_range(5, 0))
            0:       opc = 7'b0000011; // Load
            1:       opc = 7'b0100011; // Store
            2:       opc = 7'b1100011; // Branch
            3:       opc = 7'b1101111; // JAL
            4:       opc = 7'b1100111; // JALR
            default: opc = 7'b0010111; // AUIPC
        endcase
        return {r[31:7], opc};
    endfunction

    function automatic rv_pkg::reg_addr_t rand_reg(input int lo, input int hi);
        return rv_pkg::reg_addr_t'($urandom_range(hi, lo));
    endfunction

    // Architectural result of one instruction and whether it writes a register
    function automatic logic model_result(input rv_pkg::instr_t ins, output rv_pkg::word_t val);
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        logic          known;
        a     = model_regs[ins[19:15]];
        b     = (ins[6:0] == rv_pkg::OPC_OP_IMM) ? {{20{ins[31]}}, ins[31:20]}
                                                 : model_regs[ins[24:20]];
        known = 1'b1;
        val   = '0;
        if (ins[6:0] == rv_pkg::OPC_LUI) begin
            val = {ins[31:12], 12'h000};
        end else if (ins[6:0] == rv_pkg::OPC_OP || ins[6:0] == rv_pkg::OPC_OP_IMM) begin
            case (ins[14:12])
                3'd0: val = (ins[6:0] == rv_pkg::OPC_OP && ins[30]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (ins[30]) val = $signed(a) >>> b[4:0];
                    else val = a >> b[4:0];
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            known = 1'b0;
        end
        return known && (ins[11:7] != 5'd0);
    endfunction

    task automatic issue_one(input rv_pkg::instr_t ins, input int tid);
        expect_t       e;
        rv_pkg::word_t val;
        @(posedge clk);
        #1;
        issue       = 1'b1;
        instr       = ins;
        e.tag       = edge_count + 1;
        e.test_id   = tid[2:0];
        e.writes    = model_result(ins, val);
        e.exp.valid = e.writes;
        e.exp.rd    = ins[11:7];
        e.exp.data  = val;
        if (e.writes) model_regs[ins[11:7]] = val;
        expected_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            issue = 1'b0;
            instr = $urandom; // Junk that must be ignored
        end
    endtask

    task automatic random_r(input int tid, input rv_pkg::reg_addr_t rs1,
            input rv_pkg::reg_addr_t rs2, input rv_pkg::reg_addr_t rd);
        logic [2:0] f3;
        logic       alt;
        f3  = 3'($urandom_range(7, 0));
        alt = (f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0);
        issue_one(enc_r(alt, rs2, rs1, f3, rd), tid);
    endtask

    task automatic random_i(input int tid, input rv_pkg::reg_addr_t rs1,
            input rv_pkg::reg_addr_t rd);
        logic [2:0] f3;
        logic       alt;
        f3  = 3'($urandom_range(7, 0));
        alt = (f3 == 3'd5) && $urandom_range(1, 0);
        if (f3 == 3'd1 || f3 == 3'd5) begin
            issue_one(enc_i({1'b0, alt, 5'b0, 5'($urandom)}, rs1, f3, rd), tid);
        end else begin
            issue_one(enc_i(12'($urandom), rs1, f3, rd), tid);
        end
    endtask

    task automatic check_retire(input string name, input rv_pkg::retire_t exp,
            input rv_pkg::retire_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected v=%0b rd=x%0d data=%h, actual v=%0b rd=x%0d data=%h",
                     name, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data);
        end
    endtask

    task automatic check_quiet(input string name, input rv_pkg::retire_t act);
        if (act.valid !== 1'b0) begin
            errors++;
            $display("[FAIL] %s: expected valid=0, actual valid=%b rd=x%0d data=%h",
                     name, act.valid, act.rd, act.data);
        end
    endtask

    always @(posedge clk) begin
        edge_count = edge_count + 1;
        if (edge_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d", errors);
            $display("Finished with errors");
            $finish;
        end
    end

    // Retire is stable at the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (expected_q.size() > 0 && expected_q[0].tag + 2 == edge_count) begin
            e = expected_q.pop_front();
            if (e.writes) check_retire(test_label(e.test_id), e.exp, retire);
            else check_quiet(test_label(e.test_id), retire);
        end else begin
            check_quiet(rst ? "reset" : "idle", retire);
        end
    end

    initial begin
        rv_pkg::reg_addr_t a;
        rv_pkg::reg_addr_t b;
        int                kind;
        int                gap;
        void'($urandom(32'h083099dc));
        rst   = 1'b1;
        issue = 1'b0;
        instr = '0;
        for (int i = 0; i < rv_pkg::REG_COUNT; i++) model_regs[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        idle(2);

        for (int r = 1; r < 32; r++) begin
            issue_one({20'($urandom), 5'(r), rv_pkg::OPC_LUI}, 0);
            issue_one(enc_i(12'($urandom), 5'(r), 3'd0, 5'(r)), 0);
        end

        for (int k = 0; k < 40; k++) begin
            random_r(1, rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31));
        end
        for (int k = 0; k < 10; k++) begin
            a = rand_reg(1, 31);
            b = rand_reg(1, 31);
            issue_one(enc_r(1'b0, b, a, 3'd0, rand_reg(1, 31)), 1); // ADD then SUB
            issue_one(enc_r(1'b1, b, a, 3'd0, rand_reg(1, 31)), 1);
            issue_one(enc_r(1'b0, b, a, 3'd5, rand_reg(1, 31)), 1); // SRL then SRA
            issue_one(enc_r(1'b1, b, a, 3'd5, rand_reg(1, 31)), 1);
        end

        for (int k = 0; k < 40; k++) random_i(2, rand_reg(0, 31), rand_reg(0, 31));
        for (int k = 0; k < 10; k++) begin
            a = rand_reg(1, 31);
            b = rand_reg(1, 31);
            issue_one(enc_i({1'b1, 11'($urandom)}, a, 3'd2, b), 2); // Negative immediate
            issue_one(enc_i({1'b1, 11'($urandom)}, a, 3'd3, rand_reg(1, 31)), 2);
            issue_one({20'($urandom), rand_reg(1, 31), rv_pkg::OPC_LUI}, 2);
        end

        for (int g = 0; g < 3; g++) begin
            a = rand_reg(1, 31);
            for (int k = 0; k < 10; k++) begin
                b = rand_reg(1, 31);
                if (k % 2 == 0) random_i(3, a, b);
                else random_r(3, rand_reg(0, 31), a, b);
                a = b;
                idle(g);
            end
        end

        issue_one(enc_r(1'b0, rand_reg(1, 31), rand_reg(1, 31), 3'd0, 5'd0), 4);
        random_i(4, rand_reg(1, 31), 5'd0);
        issue_one({20'($urandom), 5'd0, rv_pkg::OPC_LUI}, 4);
        random_r(4, rand_reg(1, 31), rand_reg(1, 31), 5'd0);
        random_i(4, 5'd0, rand_reg(1, 31)); // Must not see the x0 write above
        random_r(4, 5'd0, rand_reg(1, 31), rand_reg(1, 31));
        random_r(4, rand_reg(1, 31), 5'd0, rand_reg(1, 31));
        issue_one(enc_r(1'b1, 5'd0, 5'd0, 3'd0, rand_reg(1, 31)), 4);
        for (int k = 0; k < 6; k++) issue_one(enc_unsupported(), 4);
        issue_one(enc_r(1'b0, 5'd0, rand_reg(1, 31), 3'd6, rand_reg(1, 31)), 4);
        issue_one(enc_r(1'b0, 5'd0, rand_reg(1, 31), 3'd6, rand_reg(1, 31)), 4);

        for (int k = 0; k < 600; k++) begin
            kind = $urandom_range(7, 0);
            if (kind < 3) random_r(5, rand_reg(0, 7), rand_reg(0, 7), rand_reg(0, 7));
            else if (kind < 6) random_i(5, rand_reg(0, 7), rand_reg(0, 7));
            else if (kind == 6) issue_one({20'($urandom), rand_reg(0, 7), rv_pkg::OPC_LUI}, 5);
            else issue_one(enc_unsupported(), 5);
            gap = $urandom_range(3, 0);
            if (gap >= 2) idle(gap - 1);
        end

        idle(4);
        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d expected retires never appeared", expected_q.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== source/rv32_int_pipe.sv ====
// Three-stage integer pipeline top with decode, execute and write-back registers
module rv32_int_pipe (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue,
    input  rv_pkg::instr_t  instr,
    output rv_pkg::retire_t retire
);

    logic              dec_valid;
    rv_pkg::instr_t    dec_instr;
    rv_pkg::decoded_t  dec;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     operand_a;
    rv_pkg::word_t     operand_b;
    rv_pkg::ex_stage_t ex_d;
    rv_pkg::ex_stage_t ex_q;
    rv_pkg::word_t     alu_result;
    logic              ex_wr;

    // Decode stage register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_instr <= '0;
        end else begin
            dec_valid <= issue;
            if (issue) begin
                dec_instr <= instr;
            end
        end
    end

    instr_decoder u_decoder (
        .instr (dec_instr),
        .valid (dec_valid),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (ex_wr),
        .wr_addr  (ex_q.rd),
        .wr_data  (alu_result)
    );

    operand_forward u_forward (
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_writes (ex_wr),
        .ex_rd     (ex_q.rd),
        .ex_result (alu_result),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    always_comb begin
        ex_d.valid     = dec.valid;
        ex_d.op        = dec.op;
        ex_d.operand_a = operand_a;
        ex_d.operand_b = operand_b;
        ex_d.rd        = dec.rd;
        ex_d.writes    = dec.writes;
    end

    // Execute stage register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

    alu u_alu (
        .op        (ex_q.op),
        .operand_a (ex_q.operand_a),
        .operand_b (ex_q.operand_b),
        .result    (alu_result)
    );

    assign ex_wr = ex_q.valid && ex_q.writes;

    // Write-back register loads on the edge of the register file write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_wr;
            retire.rd    <= ex_q.rd;
            retire.data  <= alu_result;
        end
    end

endmodule

// ==== source/alu.sv ====
// Integer ALU for the ten register and immediate operations
module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   operand_a,
    input  rv_pkg::word_t   operand_b,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b[4:0];
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: begin
                result = operand_a + operand_b;
            end
            rv_pkg::ALU_SUB: begin
                result = operand_a - operand_b;
            end
            rv_pkg::ALU_SLL: begin
                result = operand_a << shamt;
            end
            rv_pkg::ALU_SLT: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_pkg::ALU_SLTU: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_pkg::ALU_XOR: begin
                result = operand_a ^ operand_b;
            end
            rv_pkg::ALU_SRL: begin
                result = operand_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                result = $signed(operand_a) >>> shamt; // Sign fill
            end
            rv_pkg::ALU_OR: begin
                result = operand_a | operand_b;
            end
            rv_pkg::ALU_AND: begin
                result = operand_a & operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== source/operand_forward.sv ====
// Operand selection with bypass from the execute stage and immediate mux
module operand_forward (
    input  rv_pkg::decoded_t  dec,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  logic              ex_writes,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::word_t     ex_result,
    output rv_pkg::word_t     operand_a,
    output rv_pkg::word_t     operand_b
);

    logic          fwd_a;
    logic          fwd_b;
    rv_pkg::word_t rs2_live;

    // ex_writes is never set for x0
    assign fwd_a = ex_writes && (ex_rd == dec.rs1);
    assign fwd_b = ex_writes && (ex_rd == dec.rs2);

    assign operand_a = fwd_a ? ex_result : rs1_data;
    assign rs2_live  = fwd_b ? ex_result : rs2_data;
    assign operand_b = dec.use_imm ? dec.imm : rs2_live; // I-type and LUI

endmodule

// ==== source/reg_file.sv ====
// Integer register file, 32 words, two read ports and one write port
module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t    wr_data
);

    rv_pkg::word_t regs [rv_pkg::REG_COUNT];

    // Decoder never writes x0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/instr_decoder.sv ====
// Instruction decoder with immediate generation for the integer ALU subset
module instr_decoder (
    input  rv_pkg::instr_t   instr,
    input  logic             valid,
    output rv_pkg::decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       supported;
    rv_pkg::word_t i_imm;
    rv_pkg::word_t u_imm;
    rv_pkg::word_t shamt;

    // Bit 30 only matters for ADD/SUB and SRL/SRA
    function automatic rv_pkg::alu_op_t op_of(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_t op;
        case (f3)
            rv_pkg::F3_ADD:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:  op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
            default:         op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign i_imm = {{20{instr[31]}}, instr[31:20]}; // Sign extended
    assign u_imm = {instr[31:12], 12'b0};
    assign shamt = {27'b0, instr[24:20]};

    always_comb begin
        supported   = 1'b0;
        dec         = '0;
        dec.valid   = valid;
        dec.op      = rv_pkg::ALU_ADD;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        case (opcode)
            rv_pkg::OPC_OP: begin
                supported = 1'b1;
                dec.op    = op_of(funct3, instr[30]);
            end
            rv_pkg::OPC_OP_IMM: begin
                supported   = 1'b1;
                dec.use_imm = 1'b1;
                // ADDI ignores bit 30, SRAI needs it
                dec.op      = op_of(funct3, instr[30] && (funct3 == rv_pkg::F3_SR));
                if (funct3 == rv_pkg::F3_SLL || funct3 == rv_pkg::F3_SR) begin
                    dec.imm = shamt;
                end else begin
                    dec.imm = i_imm;
                end
            end
            rv_pkg::OPC_LUI: begin
                supported   = 1'b1;
                dec.use_imm = 1'b1;
                dec.rs1     = '0; // x0 + imm
                dec.imm     = u_imm;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        dec.writes = valid && supported && (dec.rd != '0);
    end

endmodule

// ==== source/rv_pkg.sv ====
// Widths, opcodes, funct3 codes, ALU operation enum and pipeline stage records
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // Major opcodes of the kept groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        logic      use_imm;   // Immediate replaces rs2 value
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      writes;    // Low for x0 and unsupported
    } decoded_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        word_t     operand_a;
        word_t     operand_b;
        reg_addr_t rd;
        logic      writes;
    } ex_stage_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage
